/* verilog/complexFir_macros.svh */
// Width and size constants for the streaming complex FIR filter.
// Included by the package and by every RTL file that sizes arithmetic.
`ifndef COMPLEXFIR_MACROS_SVH
`define COMPLEXFIR_MACROS_SVH

// Default number of filter taps.
`define FIR_LENGTH 10

// Width of one real or imaginary part of a sample or a coefficient.
`define FIR_DATA_WIDTH 8

// One part of a complex product is the sum or difference of two 8x8 products.
// Two 16-bit products added together need one extra bit.
`define FIR_PRODUCT_WIDTH 17

// The product width plus four bits, enough to add ten taps without overflow.
`define FIR_OUT_WIDTH 21

`endif

/* verilog/complexFirPkg.sv */
// Shared types and the fixed coefficient table of the complex FIR filter.
// Modules import it inside their bodies and use scoped names in their ports.
`include "complexFir_macros.svh"

package complexFirPkg;

	// One complex input sample.
	typedef struct packed {
		logic signed [`FIR_DATA_WIDTH-1:0] re;
		logic signed [`FIR_DATA_WIDTH-1:0] im;
	} sample_t;

	// One complex filter tap, laid out like a sample.
	typedef struct packed {
		logic signed [`FIR_DATA_WIDTH-1:0] re;
		logic signed [`FIR_DATA_WIDTH-1:0] im;
	} coefficient_t;

	// One complex product of a sample and a tap.
	typedef struct packed {
		logic signed [`FIR_PRODUCT_WIDTH-1:0] re;
		logic signed [`FIR_PRODUCT_WIDTH-1:0] im;
	} product_t;

	// One full convolution result.
	typedef struct packed {
		logic signed [`FIR_OUT_WIDTH-1:0] re;
		logic signed [`FIR_OUT_WIDTH-1:0] im;
	} firOut_t;

	// Entry j is the tap applied to the sample received j strobes ago.
	// The two extreme entries exercise the full product range.
	parameter coefficient_t coefficientTable [0:`FIR_LENGTH-1] = '{
		'{re: 8'sd1, im: 8'sd0},
		'{re: 8'sd2, im: -8'sd1},
		'{re: -8'sd3, im: 8'sd4},
		'{re: 8'sd5, im: 8'sd6},
		'{re: -8'sd128, im: 8'sd127},
		'{re: 8'sd127, im: -8'sd128},
		'{re: 8'sd7, im: -8'sd7},
		'{re: 8'sd0, im: 8'sd9},
		'{re: -8'sd10, im: 8'sd0},
		'{re: 8'sd12, im: -8'sd13}
	};

endpackage

/* verilog/coefficientRom.sv */
// Streams the fixed coefficient table into the tap register after a start pulse.
// Entries leave last index first, so that entry j ends up in tap j.
`timescale 1ns/1ps

module coefficientRom #(
	parameter int LENGTH = 10
) (
	input  logic clock,
	input  logic rstN,
	input  logic romStart,
	output logic coefficientValid,
	output logic romDone,
	output complexFirPkg::coefficient_t coefficient
);

	import complexFirPkg::*;

	// A single tap still needs a one-bit index.
	localparam int INDEX_WIDTH = (LENGTH > 1) ? $clog2(LENGTH) : 1;

	logic [INDEX_WIDTH-1:0] index;
	logic active;

	// The index counts down from the last table entry while the stream is active.
	// A start pulse loads it, and the stream ends after entry 0 has been sent.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			index <= '0;
			active <= 1'b0;
		end else if (romStart) begin
			index <= INDEX_WIDTH'(LENGTH - 1);
			active <= 1'b1;
		end else if (active) begin
			if (index == '0) begin
				active <= 1'b0;
			end else begin
				index <= index - 1'b1;
			end
		end
	end

	// The table lookup follows the registered index, so the first coefficient
	// appears the edge after romStart.
	always_comb begin
		coefficient = coefficientTable[index];
	end

	assign coefficientValid = active;

	// Done is flagged together with the last coefficient, which is entry 0.
	assign romDone = active && (index == '0);

endmodule

/* verilog/tapShiftRegister.sv */
// Enabled shift register with all entries visible at once.
// Serves as the delay line for samples and as the tap register for coefficients.
`timescale 1ns/1ps

module tapShiftRegister #(
	parameter int LENGTH = 10,
	parameter type payload_t = logic [15:0]
) (
	input  logic clock,
	input  logic rstN,
	input  logic shift,
	input  payload_t dataIn,
	output payload_t taps [LENGTH]
);

	// Each shift moves every entry up by one place.
	// The new value enters entry 0 and the oldest entry is dropped.
	// Reset clears the whole history, so the filter starts from zero.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < LENGTH; i++) begin
				taps[i] <= '0;
			end
		end else if (shift) begin
			for (int i = LENGTH - 1; i > 0; i--) begin
				taps[i] <= taps[i - 1];
			end
			taps[0] <= dataIn;
		end
	end

endmodule

/* verilog/complexTapMultiplier.sv */
// First arithmetic stage of the filter.
// Forms one complex product per tap and registers all of them with a valid flag.
`timescale 1ns/1ps
`include "complexFir_macros.svh"

module complexTapMultiplier #(
	parameter int LENGTH = 10
) (
	input  logic clock,
	input  logic rstN,
	input  logic inValid,
	input  complexFirPkg::sample_t samples [LENGTH],
	input  complexFirPkg::coefficient_t coefficients [LENGTH],
	output complexFirPkg::product_t products [LENGTH],
	output logic productValid
);

	import complexFirPkg::*;

	// The four signed partial products of each tap.
	// They are sized to the product width so that the sums below are exact.
	logic signed [`FIR_PRODUCT_WIDTH-1:0] reRe [LENGTH];
	logic signed [`FIR_PRODUCT_WIDTH-1:0] imIm [LENGTH];
	logic signed [`FIR_PRODUCT_WIDTH-1:0] reIm [LENGTH];
	logic signed [`FIR_PRODUCT_WIDTH-1:0] imRe [LENGTH];

	product_t productNext [LENGTH];

	// (a + jb)(c + jd) = (ac - bd) + j(ad + bc).
	always_comb begin
		for (int j = 0; j < LENGTH; j++) begin
			reRe[j] = samples[j].re * coefficients[j].re;
			imIm[j] = samples[j].im * coefficients[j].im;
			reIm[j] = samples[j].re * coefficients[j].im;
			imRe[j] = samples[j].im * coefficients[j].re;
			productNext[j].re = reRe[j] - imIm[j];
			productNext[j].im = reIm[j] + imRe[j];
		end
	end

	// Products are captured only for an accepted sample.
	// The flag follows inValid by one cycle.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int j = 0; j < LENGTH; j++) begin
				products[j] <= '0;
			end
			productValid <= 1'b0;
		end else begin
			productValid <= inValid;
			if (inValid) begin
				for (int j = 0; j < LENGTH; j++) begin
					products[j] <= productNext[j];
				end
			end
		end
	end

endmodule

/* verilog/complexAccumulator.sv */
// Second arithmetic stage of the filter.
// Adds the products of all taps and registers the result with outValid.
`timescale 1ns/1ps
`include "complexFir_macros.svh"

module complexAccumulator #(
	parameter int LENGTH = 10
) (
	input  logic clock,
	input  logic rstN,
	input  logic productValid,
	input  complexFirPkg::product_t products [LENGTH],
	output complexFirPkg::firOut_t dataOut,
	output logic outValid
);

	import complexFirPkg::*;

	firOut_t sum;

	// Each product part is sign-extended to the output width before it is added.
	// The output width covers the worst case, so the sum never wraps.
	always_comb begin
		sum = '0;
		for (int j = 0; j < LENGTH; j++) begin
			sum.re = sum.re + `FIR_OUT_WIDTH'(products[j].re);
			sum.im = sum.im + `FIR_OUT_WIDTH'(products[j].im);
		end
	end

	// dataOut keeps the last result between strobes.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			dataOut <= '0;
			outValid <= 1'b0;
		end else begin
			outValid <= productValid;
			if (productValid) begin
				dataOut <= sum;
			end
		end
	end

endmodule

/* verilog/firControl.sv */
// Control FSM of the complex FIR filter.
// Steps through idle, coefficient load, run and stop, and gates the sample strobe.
`timescale 1ns/1ps

module firControl (
	input  logic clock,
	input  logic rstN,
	input  logic loadCoefficients,
	input  logic stopFilter,
	input  logic sampleValid,
	input  logic romDone,
	output logic romStart,
	output logic sampleShift,
	output logic coefficientsLoaded
);

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		RUN,
		STOP
	} state_t;

	state_t state;
	state_t stateNext;

	// IDLE waits for a load request.
	// LOAD waits until the ROM has sent its last coefficient.
	// RUN accepts samples until a stop request, and STOP holds until reset.
	always_comb begin
		stateNext = state;
		case (state)
			IDLE: begin
				if (loadCoefficients) begin
					stateNext = LOAD;
				end
			end
			LOAD: begin
				if (romDone) begin
					stateNext = RUN;
				end
			end
			RUN: begin
				if (stopFilter) begin
					stateNext = STOP;
				end
			end
			default: begin
				stateNext = STOP;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= IDLE;
		end else begin
			state <= stateNext;
		end
	end

	// The ROM start is a single-cycle pulse, since IDLE is left on the same edge.
	assign romStart = (state == IDLE) && loadCoefficients;

	// Samples outside RUN are dropped.
	assign sampleShift = (state == RUN) && sampleValid;

	// Loaded stays high after a stop, because the taps are still in place.
	assign coefficientsLoaded = (state == RUN) || (state == STOP);

endmodule

/* verilog/complexFir.sv */
// Top level of the streaming complex FIR filter.
// A load pulse fills the taps from the table, after which strobed samples
// produce one convolution result each, three edges later.
`timescale 1ns/1ps
`include "complexFir_macros.svh"

module complexFir #(
	parameter int LENGTH = `FIR_LENGTH
) (
	input  logic clock,
	input  logic rstN,
	input  logic loadCoefficients,
	input  logic stopFilter,
	input  logic sampleValid,
	input  complexFirPkg::sample_t sampleIn,
	output logic coefficientsLoaded,
	output logic outValid,
	output complexFirPkg::firOut_t dataOut
);

	import complexFirPkg::*;

	logic romStart;
	logic romDone;
	logic coefficientValid;
	logic sampleShift;
	logic sampleShiftDelayed;
	logic productValid;

	coefficient_t coefficient;
	coefficient_t coefficientTaps [LENGTH];
	sample_t sampleTaps [LENGTH];
	product_t products [LENGTH];

	firControl firControl_i (
		.clock(clock),
		.rstN(rstN),
		.loadCoefficients(loadCoefficients),
		.stopFilter(stopFilter),
		.sampleValid(sampleValid),
		.romDone(romDone),
		.romStart(romStart),
		.sampleShift(sampleShift),
		.coefficientsLoaded(coefficientsLoaded)
	);

	coefficientRom #(.LENGTH(LENGTH)) coefficientRom_i (
		.clock(clock),
		.rstN(rstN),
		.romStart(romStart),
		.coefficientValid(coefficientValid),
		.romDone(romDone),
		.coefficient(coefficient)
	);

	// The coefficient register shifts only while the ROM streams.
	tapShiftRegister #(.LENGTH(LENGTH), .payload_t(coefficient_t)) coefficientShift_i (
		.clock(clock),
		.rstN(rstN),
		.shift(coefficientValid),
		.dataIn(coefficient),
		.taps(coefficientTaps)
	);

	// Delay line of the input samples, newest in entry 0.
	tapShiftRegister #(.LENGTH(LENGTH), .payload_t(sample_t)) sampleShift_i (
		.clock(clock),
		.rstN(rstN),
		.shift(sampleShift),
		.dataIn(sampleIn),
		.taps(sampleTaps)
	);

	// The multiplier sees the new delay line one cycle after the shift.
	// Its valid flag is delayed to match.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			sampleShiftDelayed <= 1'b0;
		end else begin
			sampleShiftDelayed <= sampleShift;
		end
	end

	complexTapMultiplier #(.LENGTH(LENGTH)) complexTapMultiplier_i (
		.clock(clock),
		.rstN(rstN),
		.inValid(sampleShiftDelayed),
		.samples(sampleTaps),
		.coefficients(coefficientTaps),
		.products(products),
		.productValid(productValid)
	);

	complexAccumulator #(.LENGTH(LENGTH)) complexAccumulator_i (
		.clock(clock),
		.rstN(rstN),
		.productValid(productValid),
		.products(products),
		.dataOut(dataOut),
		.outValid(outValid)
	);

endmodule

/* verif/clockGenerator.sv */
// Free-running clock source for the testbench.
// The clock starts low and has a 10 ns period.
`timescale 1ns/1ps

module clockGenerator #(
	parameter int HALF_PERIOD = 5
) (
	output logic clock
);

	// The first rising edge comes half a period after time zero.
	initial begin
		clock = 1'b0;
		forever begin
			#HALF_PERIOD clock = ~clock;
		end
	end

endmodule

/* verif/complexFirTb.sv */
// Testbench for the streaming complex FIR filter.
// Stimulus and expected results come from the patterns file. Every result is also
// compared with a reference convolution over the fixed coefficient table.
`timescale 1ns/1ps
`include "complexFir_macros.svh"

module complexFirTb;

	import complexFirPkg::*;

	logic clock;
	logic rstN;
	logic loadCoefficients;
	logic stopFilter;
	logic sampleValid;
	sample_t sampleIn;
	logic coefficientsLoaded;
	logic outValid;
	firOut_t dataOut;

	// Columns of the patterns file, one entry per data line.
	int rowValid [$];
	int rowInRe [$];
	int rowInIm [$];
	int rowExpRe [$];
	int rowExpIm [$];

	// Results still in flight, in the order in which their samples were accepted.
	int dueCycle [$];
	int modelRe [$];
	int modelIm [$];
	int fileRe [$];
	int fileIm [$];

	// Reference delay line, with the newest sample in entry 0.
	int historyRe [`FIR_LENGTH] = '{default: 0};
	int historyIm [`FIR_LENGTH] = '{default: 0};

	logic [15:0] lfsrState = 16'd15;
	int cycleCount = 0;
	int cycleLimit = 50;
	int row = 0;

	clockGenerator clockGenerator_i (.clock(clock));

	complexFir complexFir_i (
		.clock(clock),
		.rstN(rstN),
		.loadCoefficients(loadCoefficients),
		.stopFilter(stopFilter),
		.sampleValid(sampleValid),
		.sampleIn(sampleIn),
		.coefficientsLoaded(coefficientsLoaded),
		.outValid(outValid),
		.dataOut(dataOut)
	);

	// Prints the reason and ends the run.
	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic checkValue(input string what, input int actual, input int expected);
		if (actual !== expected) begin
			abortRun($sformatf("FAILED at %0t: %s is %0d, expected %0d.", $time, what,
				actual, expected));
		end
	endtask

	// Fibonacci LFSR with taps 16, 14, 13 and 11.
	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	// Two LFSR bits give an idle gap of 0 to 3 cycles.
	task automatic pickGap(output int gap);
		gap = 0;
		for (int b = 0; b < 2; b++) begin
			lfsrState = lfsrNext(lfsrState);
			gap = gap * 2 + int'(lfsrState[0]);
		end
	endtask

	// Lines starting with // are comments. Each data line has five decimal columns.
	task automatic readPatterns();
		int fd;
		int code;
		int v;
		int a;
		int b;
		int c;
		int d;
		string line;
		fd = $fopen("verif/complexFir_patterns.txt", "r");
		if (fd == 0) begin
			abortRun("The patterns file verif/complexFir_patterns.txt could not be opened.");
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
					if ($sscanf(line, "%d %d %d %d %d", v, a, b, c, d) != 5) begin
						abortRun($sformatf("The patterns file has a bad line: %s", line));
					end else begin
						rowValid.push_back(v);
						rowInRe.push_back(a);
						rowInIm.push_back(b);
						rowExpRe.push_back(c);
						rowExpIm.push_back(d);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Shifts the reference delay line and queues the expected result.
	// (a + jb)(c + jd) = (ac - bd) + j(ad + bc), summed over all taps.
	// The output is due four edges after the drive, which is three after the sampling edge.
	task automatic acceptSample(input int index);
		int sumRe;
		int sumIm;
		sumRe = 0;
		sumIm = 0;
		for (int k = `FIR_LENGTH - 1; k > 0; k--) begin
			historyRe[k] = historyRe[k - 1];
			historyIm[k] = historyIm[k - 1];
		end
		historyRe[0] = rowInRe[index];
		historyIm[0] = rowInIm[index];
		for (int k = 0; k < `FIR_LENGTH; k++) begin
			sumRe += historyRe[k] * coefficientTable[k].re - historyIm[k] * coefficientTable[k].im;
			sumIm += historyRe[k] * coefficientTable[k].im + historyIm[k] * coefficientTable[k].re;
		end
		modelRe.push_back(sumRe);
		modelIm.push_back(sumIm);
		fileRe.push_back(rowExpRe[index]);
		fileIm.push_back(rowExpIm[index]);
		dueCycle.push_back(cycleCount + 4);
	endtask

	// Strobes one sample for a cycle, then idles for the gap.
	// Only rows marked valid are expected to come out of the filter.
	task automatic driveSample(input int index, input int gap);
		sampleIn.re = 8'(rowInRe[index]);
		sampleIn.im = 8'(rowInIm[index]);
		sampleValid = 1'b1;
		if (rowValid[index] == 1) begin
			acceptSample(index);
		end
		@(posedge clock);
		#1;
		sampleValid = 1'b0;
		repeat (gap) begin
			@(posedge clock);
			#1;
		end
	endtask

	// Watches every edge for the timeout and for results.
	// Any outValid without a sample in flight is an error.
	always @(posedge clock) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			abortRun($sformatf("Timeout: the run took more than %0d cycles.", cycleLimit));
		end else if (outValid === 1'b1) begin
			if (dueCycle.size() == 0) begin
				abortRun($sformatf("outValid was raised at %0t with no sample in flight.", $time));
			end else begin
				checkValue("outValid cycle", cycleCount, dueCycle.pop_front());
				checkValue("dataOut.re against the model", dataOut.re, modelRe.pop_front());
				checkValue("dataOut.im against the model", dataOut.im, modelIm.pop_front());
				checkValue("dataOut.re against the file", dataOut.re, fileRe.pop_front());
				checkValue("dataOut.im against the file", dataOut.im, fileIm.pop_front());
			end
		end
	end

	initial begin
		int gap;
		rstN = 1'b0;
		loadCoefficients = 1'b0;
		stopFilter = 1'b0;
		sampleValid = 1'b0;
		sampleIn = '0;
		readPatterns();
		cycleLimit = 50 + 4 * rowValid.size();
		repeat (10) @(posedge clock);
		#1;
		rstN = 1'b1;
		// Rows before the first valid one are strobed before the load and must be dropped.
		while (row < rowValid.size() && rowValid[row] == 0) begin
			checkValue("coefficientsLoaded before the load", coefficientsLoaded, 0);
			driveSample(row, 1);
			row++;
		end
		// Loaded must rise exactly LENGTH + 1 cycles after the pulse.
		loadCoefficients = 1'b1;
		for (int k = 1; k <= `FIR_LENGTH + 1; k++) begin
			@(posedge clock);
			#1;
			loadCoefficients = 1'b0;
			checkValue("coefficientsLoaded during the load", coefficientsLoaded, k > `FIR_LENGTH);
		end
		// The last run sample has no gap, so the stop finds outputs in flight.
		while (row < rowValid.size() && rowValid[row] == 1) begin
			checkValue("coefficientsLoaded while running", coefficientsLoaded, 1);
			if (row + 1 < rowValid.size() && rowValid[row + 1] == 1) begin
				pickGap(gap);
			end else begin
				gap = 0;
			end
			driveSample(row, gap);
			row++;
		end
		stopFilter = 1'b1;
		@(posedge clock);
		#1;
		stopFilter = 1'b0;
		while (row < rowValid.size()) begin
			driveSample(row, 1);
			row++;
		end
		repeat (8) @(posedge clock);
		#1;
		checkValue("coefficientsLoaded after the stop", coefficientsLoaded, 1);
		if (dueCycle.size() == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			abortRun($sformatf("%0d accepted samples never produced an output.",
				dueCycle.size()));
		end
	end

endmodule

/* verif/complexFir_patterns.txt */
// Columns: valid, input re, input im, expected output re, expected output im (decimal).
// Valid 0 marks a sample that the filter must drop, before the load or after the stop.
0 5 -5 0 0
0 100 3 0 0
1 1 0 1 0
1 0 0 2 -1
1 0 0 -3 4
1 0 0 5 6
1 0 0 -128 127
1 0 0 127 -128
1 0 0 7 -7
1 0 0 0 9
1 0 0 -10 0
1 0 0 12 -13
1 0 1 0 1
1 0 0 1 2
1 0 0 -4 -3
1 0 0 -6 5
1 0 0 -127 -128
1 0 0 128 127
1 0 0 7 7
1 0 0 -9 0
1 0 0 0 -10
1 0 0 13 12
1 -128 127 -128 127
1 127 -128 -2 254
1 -128 -128 -126 -1404
1 127 127 -1528 758
1 0 0 2935 -32391
1 0 0 -761 63745
0 -128 127 0 0
0 9 9 0 0

/* sources.f */
+incdir+verilog
verilog/complexFirPkg.sv
verilog/coefficientRom.sv
verilog/tapShiftRegister.sv
verilog/complexTapMultiplier.sv
verilog/complexAccumulator.sv
verilog/firControl.sv
verilog/complexFir.sv
verif/clockGenerator.sv
verif/complexFirTb.sv

/* Makefile */
VERILATOR = verilator
VERILATOR_FLAGS = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP = complexFirTb
FILE_LIST = sources.f
OBJ_DIR = obj_dir
SIM = $(OBJ_DIR)/V$(TOP)
PASS_TEXT = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# The output is shown and then searched for the pass message.
run: compile
	@output="$$(./$(SIM))"; \
	echo "$$output"; \
	echo "$$output" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
